// ==== source/frame_emitter.sv ====
// head and tail layout is fixed at three pre bytes, two markers and the packet number.
`default_nettype none
`include "framer_consts.svh"

module frame_emitter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire framer_pkg::frame_cmd_t cmd,
    output framer_pkg::out_beat_t      beat
);

    logic [7:0] marker;
    logic [7:0] pat_byte;
    logic [7:0] sel_byte;

    assign marker = (cmd.seg == framer_pkg::SEG_TAIL) ? `FRAMER_TAIL_BYTE
                                                      : `FRAMER_HEAD_BYTE;

    always_comb begin
        if (cmd.idx < 3'd3) begin
            pat_byte = `FRAMER_PRE_BYTE;
        end else if (cmd.idx < 3'd5) begin
            pat_byte = marker;
        end else begin
            pat_byte = cmd.pkt_num;   // last byte of head or tail.
        end
    end

    assign sel_byte = (cmd.seg == framer_pkg::SEG_BODY) ? cmd.data : pat_byte;

    // data holds between frames.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else begin
            beat.vld <= cmd.vld;
            beat.sop <= cmd.sop;
            beat.eop <= cmd.eop;
            if (cmd.vld) begin
                beat.data <= sel_byte;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_sequencer.sv ====
// starts a frame only for a fully stored packet, so the body never pops an empty buffer.
`default_nettype none
`include "framer_consts.svh"

module frame_sequencer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire framer_pkg::pkt_byte_t rd_byte,
    input  wire [8:0]              pkt_avail,
    output logic                   rd_pop,
    output logic                   pkt_done,
    output framer_pkg::frame_cmd_t cmd
);

    framer_pkg::seg_t state;
    logic [2:0]       idx;
    logic [7:0]       pkt_num;
    logic             hdr_last;
    logic             in_body;
    logic             in_pat;

    assign in_body  = (state == framer_pkg::SEG_BODY);
    assign in_pat   = (state == framer_pkg::SEG_HEAD) || (state == framer_pkg::SEG_TAIL);
    assign hdr_last = (idx == 3'(`FRAMER_HDR_LEN - 1));

    assign rd_pop   = in_body;
    assign pkt_done = (state == framer_pkg::SEG_TAIL) && hdr_last;

    // segment FSM. in the body idx only marks the first beat.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= framer_pkg::SEG_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                framer_pkg::SEG_IDLE: begin
                    idx <= '0;
                    if (pkt_avail != '0) begin
                        state <= framer_pkg::SEG_HEAD;
                    end
                end
                framer_pkg::SEG_HEAD: begin
                    if (hdr_last) begin
                        state <= framer_pkg::SEG_BODY;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                framer_pkg::SEG_BODY: begin
                    if (rd_byte.eop) begin
                        state <= framer_pkg::SEG_TAIL;
                        idx   <= '0;
                    end else begin
                        idx <= 3'd1;
                    end
                end
                framer_pkg::SEG_TAIL: begin
                    if (hdr_last) begin
                        // current packet is still counted here.
                        state <= (pkt_avail > 9'd1) ? framer_pkg::SEG_HEAD
                                                    : framer_pkg::SEG_IDLE;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    state <= framer_pkg::SEG_IDLE;
                    idx   <= '0;
                end
            endcase
        end
    end

    // packet number, wraps at 8 bits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_num <= '0;
        end else if (pkt_done) begin
            pkt_num <= pkt_num + 1'b1;
        end
    end

    always_comb begin
        cmd         = '0;
        cmd.vld     = (state != framer_pkg::SEG_IDLE);
        cmd.seg     = state;
        cmd.idx     = idx;
        cmd.pkt_num = pkt_num;
        cmd.sop     = cmd.vld && (idx == '0);
        if (in_body) begin
            cmd.data = rd_byte.data;
            cmd.eop  = rd_byte.eop;   // stored flag ends the body.
        end else begin
            cmd.eop  = in_pat && hdr_last;
        end
    end

endmodule

`default_nettype wire

// ==== source/framer_consts.svh ====
// sizes and pattern bytes are fixed at compile time; depth must stay a power of two.
`ifndef FRAMER_CONSTS_SVH
`define FRAMER_CONSTS_SVH

// buffer geometry.
`define FRAMER_FIFO_DEPTH 1024
`define FRAMER_PTR_W      10

// head and tail are the same length.
`define FRAMER_HDR_LEN    6

// head is pre, pre, pre, head, head, number.
// tail is pre, pre, pre, tail, tail, number.
`define FRAMER_PRE_BYTE   8'h55
`define FRAMER_HEAD_BYTE  8'hd5
`define FRAMER_TAIL_BYTE  8'hfd

`endif

// ==== source/framer_pkg.sv ====
// shared framer types; field order inside the structs is part of the interface.
`default_nettype none

package framer_pkg;

    // one stored input byte.
    typedef struct packed {
        logic       sop;
        logic       eop;
        logic [7:0] data;
    } pkt_byte_t;

    // sequencer segment.
    typedef enum logic [1:0] {
        SEG_IDLE = 2'd0,
        SEG_HEAD = 2'd1,
        SEG_BODY = 2'd2,
        SEG_TAIL = 2'd3
    } seg_t;

    // sequencer to emitter, one per cycle.
    typedef struct packed {
        logic       vld;
        seg_t       seg;
        logic [2:0] idx;      // position inside head or tail.
        logic [7:0] pkt_num;
        logic [7:0] data;     // body byte, zero outside the body.
        logic       sop;
        logic       eop;
    } frame_cmd_t;

    // registered output beat.
    typedef struct packed {
        logic [7:0] data;
        logic       vld;
        logic       sop;
        logic       eop;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== source/pkt_buffer.sv ====
// no back-pressure: writing into a full buffer loses bytes, and popping an empty one is ignored.
`default_nettype none
`include "framer_consts.svh"

module pkt_buffer (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [7:0]              din,
    input  wire                    din_vld,
    input  wire                    din_sop,
    input  wire                    din_eop,
    input  wire                    rd_pop,
    input  wire                    pkt_done,
    output framer_pkg::pkt_byte_t  rd_byte,
    output logic                   empty,
    output logic [8:0]             pkt_avail
);

    framer_pkg::pkt_byte_t     mem [`FRAMER_FIFO_DEPTH];
    logic [`FRAMER_PTR_W-1:0]  wr_ptr;
    logic [`FRAMER_PTR_W-1:0]  rd_ptr;
    logic [`FRAMER_PTR_W:0]    fill;
    logic                      do_pop;
    logic                      pkt_in;

    assign do_pop = rd_pop && !empty;
    assign pkt_in = din_vld && din_eop;   // a whole packet is now stored.

    // storage, no reset.
    always_ff @(posedge clk) begin
        if (din_vld) begin
            mem[wr_ptr] <= '{sop: din_sop, eop: din_eop, data: din};
        end
    end

    // show-ahead read.
    assign rd_byte = mem[rd_ptr];
    assign empty   = (fill == '0);

    // pointers wrap on their own since depth is 2**ptr_w.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (din_vld) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else begin
            case ({din_vld, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // complete packets waiting to be framed.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_avail <= '0;
        end else begin
            case ({pkt_in, pkt_done})
                2'b10:   pkt_avail <= pkt_avail + 1'b1;
                2'b01:   pkt_avail <= pkt_avail - 1'b1;
                default: pkt_avail <= pkt_avail;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pkt_framer_top.sv ====
// packets must be 1 to 256 bytes and the sender must keep the buffer from overflowing.
`default_nettype none

module pkt_framer_top (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [7:0]  din,
    input  wire        din_vld,
    input  wire        din_sop,
    input  wire        din_eop,
    output logic [7:0] dout,
    output logic       dout_vld,
    output logic       dout_sop,
    output logic       dout_eop
);

    framer_pkg::pkt_byte_t  rd_byte;
    framer_pkg::frame_cmd_t cmd;
    framer_pkg::out_beat_t  beat;
    logic [8:0]             pkt_avail;
    logic                   rd_pop;
    logic                   pkt_done;

    pkt_buffer pkt_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (din),
        .din_vld   (din_vld),
        .din_sop   (din_sop),
        .din_eop   (din_eop),
        .rd_pop    (rd_pop),
        .pkt_done  (pkt_done),
        .rd_byte   (rd_byte),
        .empty     (),
        .pkt_avail (pkt_avail)
    );

    frame_sequencer frame_sequencer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_byte   (rd_byte),
        .pkt_avail (pkt_avail),
        .rd_pop    (rd_pop),
        .pkt_done  (pkt_done),
        .cmd       (cmd)
    );

    frame_emitter frame_emitter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .beat  (beat)
    );

    assign dout     = beat.data;
    assign dout_vld = beat.vld;
    assign dout_sop = beat.sop;
    assign dout_eop = beat.eop;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/framer_pkg.sv
source/pkt_buffer.sv
source/frame_sequencer.sv
source/frame_emitter.sv
source/pkt_framer_top.sv
verif/framer_checker.sv
verif/tb_pkt_framer.sv

// ==== verif/framer_checker.sv ====
// expected beats are queued by the testbench in frame order; outputs are sampled on the falling edge.
`default_nettype none

module framer_checker (
    input wire       clk,
    input wire       rst_n,
    input wire [7:0] dout,
    input wire       dout_vld,
    input wire       dout_sop,
    input wire       dout_eop
);

    typedef struct packed {
        logic [7:0] data;
        logic       sop;
        logic       eop;
        logic       last;   // final tail byte of a frame.
    } exp_beat_t;

    exp_beat_t exp_q[$];
    int        err_count;
    logic      in_frame;

    initial begin
        err_count = 0;
        in_frame  = 1'b0;
    end

    task automatic expect_beat(input logic [7:0] data, input logic sop, input logic eop,
                               input logic last);
        exp_q.push_back('{data: data, sop: sop, eop: eop, last: last});
    endtask

    function automatic int queued();
        return exp_q.size();
    endfunction

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (exp !== got) begin
            $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, exp, got);
            err_count++;
        end
    endtask

    // all outputs rest at zero while nothing is framed.
    task automatic check_quiet();
        compare("dout", 8'h00, dout);
        compare("dout_vld", 8'h00, 8'(dout_vld));
        compare("dout_sop", 8'h00, 8'(dout_sop));
        compare("dout_eop", 8'h00, 8'(dout_eop));
    endtask

    always @(negedge clk) begin
        exp_beat_t e;
        if (!rst_n) begin
            in_frame = 1'b0;
        end else if (dout_vld) begin
            if (exp_q.size() == 0) begin
                $display("output beat at time %0t arrived with nothing left to compare", $time);
                err_count++;
            end else begin
                e = exp_q.pop_front();
                compare("dout", e.data, dout);
                compare("dout_sop", 8'(e.sop), 8'(dout_sop));
                compare("dout_eop", 8'(e.eop), 8'(dout_eop));
                in_frame = !e.last;
            end
        end else if (in_frame) begin
            $display("dout_vld dropped inside a frame at time %0t", $time);
            err_count++;
            in_frame = 1'b0;   // report a gap once.
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_pkt_framer.sv ====
// packets stay 1 to 256 bytes and the sender throttles so the buffer never overflows.
`default_nettype none
`include "framer_consts.svh"

module tb_pkt_framer;

    localparam int ROOM       = `FRAMER_FIFO_DEPTH - 64;
    localparam int ROOM_WAIT  = 4000;
    localparam int DRAIN_WAIT = 20000;

    logic       clk;
    logic       rst_n;
    logic [7:0] din;
    logic       din_vld;
    logic       din_sop;
    logic       din_eop;
    wire  [7:0] dout;
    wire        dout_vld;
    wire        dout_sop;
    wire        dout_eop;

    integer     seed;
    logic [7:0] pkt_num;   // model packet number.
    int         pass_cnt;
    int         fail_cnt;
    logic       aborted;
    int         t;

    pkt_framer_top pkt_framer_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .din_vld  (din_vld),
        .din_sop  (din_sop),
        .din_eop  (din_eop),
        .dout     (dout),
        .dout_vld (dout_vld),
        .dout_sop (dout_sop),
        .dout_eop (dout_eop)
    );

    framer_checker chk_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .dout     (dout),
        .dout_vld (dout_vld),
        .dout_sop (dout_sop),
        .dout_eop (dout_eop)
    );

    always #20 clk = ~clk;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        #2;
        din_vld = 1'b0;
        din_sop = 1'b0;
        din_eop = 1'b0;
    endtask

    task automatic drive_byte(input logic [7:0] b, input logic sop, input logic eop);
        @(posedge clk);
        #2;
        din     = b;
        din_vld = 1'b1;
        din_sop = sop;
        din_eop = eop;
    endtask

    // head or tail: pre, pre, pre, marker, marker, packet number.
    task automatic push_pattern(input logic [7:0] marker, input logic is_tail);
        int         i;
        logic [7:0] b;
        for (i = 0; i < `FRAMER_HDR_LEN; i++) begin
            b = (i < 3) ? `FRAMER_PRE_BYTE : ((i < 5) ? marker : pkt_num);
            chk_i.expect_beat(b, i == 0, i == `FRAMER_HDR_LEN - 1,
                              is_tail && (i == `FRAMER_HDR_LEN - 1));
        end
    endtask

    task automatic wait_room(input int len);
        int n;
        n = 0;
        while ((chk_i.queued() + len >= ROOM) && (n < ROOM_WAIT)) begin
            drive_idle();
            n++;
        end
        if (chk_i.queued() + len >= ROOM) begin
            $display("buffer never drained far enough to accept the next packet");
            aborted = 1'b1;
        end
    endtask

    task automatic send_packet(input int len, input int gap_max);
        int         i;
        logic [7:0] b;
        wait_room(len);
        if (!aborted) begin
            push_pattern(`FRAMER_HEAD_BYTE, 1'b0);
            for (i = 0; i < len; i++) begin
                b = 8'($random(seed));
                drive_byte(b, i == 0, i == len - 1);
                chk_i.expect_beat(b, i == 0, i == len - 1, 1'b0);
                if (i < len - 1) begin
                    repeat (rand_range(0, gap_max)) drive_idle();
                end
            end
            push_pattern(`FRAMER_TAIL_BYTE, 1'b1);
            pkt_num = pkt_num + 8'd1;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        drive_idle();
        while ((chk_i.queued() != 0) && (n < DRAIN_WAIT)) begin
            @(posedge clk);
            n++;
        end
        if (chk_i.queued() != 0) begin
            $display("%0d expected output bytes never came out", chk_i.queued());
            aborted = 1'b1;
        end
    endtask

    task automatic run_test(input int num);
        int    errs_before;
        int    i;
        string name;
        errs_before = chk_i.err_count;
        case (num)
            1: begin
                name = "quiet outputs after reset";
                for (i = 0; i < 10; i++) begin
                    @(negedge clk);
                    chk_i.check_quiet();
                end
            end
            2: begin
                name = "single 8-byte packet";
                send_packet(8, 0);
            end
            3: begin
                name = "shortest and longest packets";
                send_packet(1, 0);
                send_packet(256, 0);
            end
            4: begin
                name = "twenty back-to-back packets";
                for (i = 0; i < 20 && !aborted; i++) begin
                    send_packet(rand_range(1, 256), 0);
                end
            end
            5: begin
                name = "packet number wrap";
                for (i = 0; i < 260 && !aborted; i++) begin
                    send_packet(rand_range(1, 8), 0);
                    repeat (rand_range(0, 3)) drive_idle();
                end
            end
            default: begin
                name = "idle gaps inside packets";
                for (i = 0; i < 10 && !aborted; i++) begin
                    send_packet(rand_range(1, 64), 3);
                    repeat (rand_range(0, 3)) drive_idle();
                end
            end
        endcase
        if (!aborted) begin
            wait_drain();
        end
        if (!aborted && (chk_i.err_count == errs_before)) begin
            pass_cnt++;
            $display("test %0d (%s): passed", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d (%s): failed", num, name);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        din      = 8'h00;
        din_vld  = 1'b0;
        din_sop  = 1'b0;
        din_eop  = 1'b0;
        seed     = 32'h3c2e;
        pkt_num  = 8'd0;
        pass_cnt = 0;
        fail_cnt = 0;
        aborted  = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (t = 1; t <= 6 && !aborted; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !aborted && (chk_i.err_count == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
